//--- sources.f
common/duc_pkg.sv
common/duc_regs_pkg.sv
source/duc_settings.sv
duc_chain/interp_hold.sv
duc_chain/iq_scale.sv
duc_chain/coarse_rotator.sv
source/duc_top.sv
verification/duc_tb.sv

//--- verification/duc_tb.sv
// ------------------------------
// DUC chain testbench
// Random stimulus with a reference model
// Readback, scoreboard and stall checks
// Watchdog
// ------------------------------

`default_nettype none

module duc_tb;

  localparam int CLK_PERIOD   = 4;
  localparam int N_PHASES     = 8;
  localparam int BEATS        = 20;
  localparam int SETUP_CYCLES = 20 + N_PHASES * 10;
  localparam int MAX_OUT      = N_PHASES * BEATS * duc_pkg::MAX_INTERP;
  localparam int WATCHDOG_TIME =
    (MAX_OUT * (duc_pkg::MAX_INTERP + 4) + SETUP_CYCLES) * CLK_PERIOD * 4;

  logic               duc_clk;
  logic               i_rst_n;
  logic               i_set_stb;
  logic [7:0]         i_set_addr;
  logic [31:0]        i_set_data;
  logic [7:0]         i_rb_addr;
  logic [63:0]        o_rb_data;
  duc_pkg::duc_beat_t i_in_beat;
  logic               i_in_valid;
  logic               o_in_ready;
  duc_pkg::duc_beat_t o_out_beat;
  logic               o_out_valid;
  logic               i_out_ready;

  // Reference model state
  duc_pkg::duc_beat_t exp_q[$];
  logic [31:0]        model_freq;
  logic signed [15:0] model_scale;
  int                 model_interp;
  logic [31:0]        model_phase;
  int                 out_count;
  logic               bp_en;
  logic               gaps_en;
  logic               was_stalled;
  duc_pkg::duc_beat_t stalled_beat;
  duc_pkg::duc_beat_t exp_front;

  duc_top dut_i (
    .duc_clk     (duc_clk),
    .i_rst_n     (i_rst_n),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_rb_addr   (i_rb_addr),
    .o_rb_data   (o_rb_data),
    .i_in_beat   (i_in_beat),
    .i_in_valid  (i_in_valid),
    .o_in_ready  (o_in_ready),
    .o_out_beat  (o_out_beat),
    .o_out_valid (o_out_valid),
    .i_out_ready (i_out_ready)
  );

  initial begin
    duc_clk = 1'b0;
    forever #(CLK_PERIOD / 2) duc_clk = ~duc_clk;
  end

  task automatic report_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "Stopping at first error");
  endtask

  // ------------------------------
  // Model arithmetic
  // ------------------------------
  function automatic logic signed [15:0] scale_component(input logic signed [15:0] x,
                                                         input logic signed [15:0] s);
    longint prod;
    longint shifted;
    prod    = longint'(x) * longint'(s);
    shifted = prod >>> 14;
    if (shifted > 32767) return 16'sh7FFF;
    if (shifted < -32768) return 16'sh8000;
    return shifted[15:0];
  endfunction

  function automatic logic signed [15:0] negate_sat(input logic signed [15:0] x);
    if (x == -16'sd32768) return 16'sd32767;
    return -x;
  endfunction

  function automatic logic signed [15:0] random_component();
    case ($urandom % 8)
      0:       return 16'sh8000;
      1:       return 16'sh7FFF;
      default: return $urandom;
    endcase
  endfunction

  function automatic logic signed [15:0] random_scale();
    case ($urandom % 6)
      0:       return 16'sh8000;
      1:       return 16'sh7FFF;
      2:       return 16'sd16384;
      default: return $urandom;
    endcase
  endfunction

  // Expected output copies of one accepted input beat
  task automatic expand_beat(input duc_pkg::duc_beat_t beat);
    duc_pkg::duc_beat_t eb;
    logic signed [15:0] si;
    logic signed [15:0] sq;
    int                 k;
    si = scale_component(beat.sample.i, model_scale);
    sq = scale_component(beat.sample.q, model_scale);
    for (k = 0; k < model_interp; k++) begin
      case (model_phase[31:30])
        2'd0: begin
          eb.sample.i = si;
          eb.sample.q = sq;
        end
        2'd1: begin
          eb.sample.i = negate_sat(sq);
          eb.sample.q = si;
        end
        2'd2: begin
          eb.sample.i = negate_sat(si);
          eb.sample.q = negate_sat(sq);
        end
        default: begin
          eb.sample.i = sq;
          eb.sample.q = negate_sat(si);
        end
      endcase
      eb.last = beat.last && (k == model_interp - 1);
      exp_q.push_back(eb);
      model_phase = model_phase + model_freq;
    end
  endtask

  // ------------------------------
  // Bus drivers
  // ------------------------------
  task automatic check_readback(input logic [7:0] addr, input logic [63:0] expected);
    @(negedge duc_clk);
    i_rb_addr = addr;
    @(posedge duc_clk);
    assert (o_rb_data === expected) else
      report_error($sformatf("readback addr %0d: got %h, expected %h",
                             addr, o_rb_data, expected));
  endtask

  task automatic write_settings(input logic [31:0] freq, input logic signed [15:0] scale,
                                input logic [7:0] interp);
    @(negedge duc_clk);
    i_set_stb  = 1'b1;
    i_set_addr = duc_regs_pkg::SR_FREQ_ADDR;
    i_set_data = freq;
    @(negedge duc_clk);
    i_set_addr = duc_regs_pkg::SR_SCALE_INTERP_ADDR;
    i_set_data = {8'd0, interp, scale};
    @(negedge duc_clk);
    i_set_stb    = 1'b0;
    model_freq   = freq;
    model_scale  = scale;
    model_interp = interp;
    // Frequency write restarts the phase
    model_phase  = 32'd0;
    check_readback(duc_regs_pkg::RB_CONFIG_ADDR, {8'd0, freq, scale, interp});
    @(negedge duc_clk);
  endtask

  // Entered and left on a falling edge with valid held until accepted
  task automatic send_beat(input logic signed [15:0] i_val, input logic signed [15:0] q_val,
                           input logic last);
    duc_pkg::duc_beat_t beat;
    int unsigned        gap;
    logic               accepted;
    beat.sample.i = i_val;
    beat.sample.q = q_val;
    beat.last     = last;
    gap = gaps_en ? ($urandom % 3) : 0;
    if (gap != 0) begin
      i_in_valid = 1'b0;
      repeat (gap) @(negedge duc_clk);
    end
    i_in_beat  = beat;
    i_in_valid = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(posedge duc_clk);
      accepted = o_in_ready;
    end
    expand_beat(beat);
    @(negedge duc_clk);
  endtask

  // Output back-pressure
  always @(negedge duc_clk) begin
    i_out_ready = bp_en ? (($urandom % 4) != 0) : 1'b1;
  end

  // ------------------------------
  // Output scoreboard
  // ------------------------------
  always @(posedge duc_clk) begin
    if (i_rst_n) begin
      if (was_stalled) begin
        assert (o_out_valid && (o_out_beat === stalled_beat)) else
          report_error("stalled output beat changed or was dropped");
      end
      if (o_out_valid && i_out_ready) begin
        assert (exp_q.size() > 0) else
          report_error("output beat with no expected beat left");
        exp_front = exp_q.pop_front();
        assert (o_out_beat === exp_front) else
          report_error($sformatf("beat %0d: got i=%0d q=%0d last=%0b, exp i=%0d q=%0d last=%0b",
                                 out_count, o_out_beat.sample.i, o_out_beat.sample.q,
                                 o_out_beat.last, exp_front.sample.i, exp_front.sample.q,
                                 exp_front.last));
        out_count++;
      end
      was_stalled  = o_out_valid && !i_out_ready;
      stalled_beat = o_out_beat;
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout: the DUT did not deliver all expected output beats in time");
    $display("Test failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int                 p;
    int                 b;
    logic [31:0]        freq;
    logic signed [15:0] scale;
    logic [7:0]         interp;
    void'($urandom(5327));
    i_rst_n     = 1'b0;
    i_set_stb   = 1'b0;
    i_set_addr  = 8'd0;
    i_set_data  = 32'd0;
    i_rb_addr   = 8'd0;
    i_in_beat   = '0;
    i_in_valid  = 1'b0;
    i_out_ready = 1'b1;
    bp_en       = 1'b0;
    gaps_en     = 1'b0;
    was_stalled = 1'b0;
    out_count   = 0;
    repeat (2) @(negedge duc_clk);
    i_rst_n = 1'b1;

    // Reset readback values
    check_readback(duc_regs_pkg::RB_COMPAT_ADDR, {32'd0, duc_regs_pkg::COMPAT_NUM});
    check_readback(duc_regs_pkg::RB_MAX_INTERP_ADDR, 64'(duc_pkg::MAX_INTERP));
    check_readback(duc_regs_pkg::RB_CONFIG_ADDR, {8'd0, 32'd0, 16'd16384, 8'd1});
    check_readback(8'd7, duc_regs_pkg::RB_BAD_ADDR);

    // Pass-through first, then interp, scale, rotation and stalls in turn
    for (p = 0; p < N_PHASES; p++) begin
      freq   = 32'd0;
      scale  = 16'sd16384;
      interp = 8'd1;
      if (p >= 1) interp = 8'(1 + ($urandom % duc_pkg::MAX_INTERP));
      if (p >= 2) scale = random_scale();
      if (p == 3) freq = 32'h4000_0000;
      if (p >= 4) freq = $urandom;
      write_settings(freq, scale, interp);
      bp_en   = (p >= 4);
      gaps_en = (p >= 4);
      for (b = 0; b < BEATS; b++) begin
        send_beat(random_component(), random_component(),
                  (b == BEATS - 1) || (($urandom % 4) == 0));
      end
      i_in_valid = 1'b0;
      while (exp_q.size() != 0) @(negedge duc_clk);
    end

    // Chain must be empty once every expected beat has left
    repeat (4) @(negedge duc_clk);
    assert (!o_out_valid && o_in_ready) else
      report_error($sformatf("chain not empty after %0d output beats", out_count));
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/duc_top.sv
// ------------------------------
// DUC top level
// Settings block and three-stage sample chain
// ------------------------------

`default_nettype none

module duc_top (
  input  wire                  duc_clk,
  input  wire                  i_rst_n,
  // Settings bus and readback
  input  wire                  i_set_stb,
  input  wire  [7:0]           i_set_addr,
  input  wire  [31:0]          i_set_data,
  input  wire  [7:0]           i_rb_addr,
  output logic [63:0]          o_rb_data,
  // Sample input
  input  duc_pkg::duc_beat_t   i_in_beat,
  input  wire                  i_in_valid,
  output logic                 o_in_ready,
  // Sample output
  output duc_pkg::duc_beat_t   o_out_beat,
  output logic                 o_out_valid,
  input  wire                  i_out_ready
);

  duc_regs_pkg::duc_cfg_t cfg;
  logic                   freq_load;

  duc_pkg::duc_beat_t interp_beat;
  logic               interp_valid;
  logic               interp_ready;
  duc_pkg::duc_beat_t scale_beat;
  logic               scale_valid;
  logic               scale_ready;

  duc_settings duc_settings_i (
    .duc_clk     (duc_clk),
    .i_rst_n     (i_rst_n),
    .i_set_stb   (i_set_stb),
    .i_set_addr  (i_set_addr),
    .i_set_data  (i_set_data),
    .i_rb_addr   (i_rb_addr),
    .o_rb_data   (o_rb_data),
    .o_cfg       (cfg),
    .o_freq_load (freq_load)
  );

  interp_hold interp_hold_i (
    .duc_clk  (duc_clk),
    .i_rst_n  (i_rst_n),
    .i_interp (cfg.interp),
    .i_beat   (i_in_beat),
    .i_valid  (i_in_valid),
    .o_ready  (o_in_ready),
    .o_beat   (interp_beat),
    .o_valid  (interp_valid),
    .i_ready  (interp_ready)
  );

  iq_scale iq_scale_i (
    .duc_clk (duc_clk),
    .i_rst_n (i_rst_n),
    .i_scale (cfg.scale),
    .i_beat  (interp_beat),
    .i_valid (interp_valid),
    .o_ready (interp_ready),
    .o_beat  (scale_beat),
    .o_valid (scale_valid),
    .i_ready (scale_ready)
  );

  coarse_rotator coarse_rotator_i (
    .duc_clk     (duc_clk),
    .i_rst_n     (i_rst_n),
    .i_freq      (cfg.freq),
    .i_freq_load (freq_load),
    .i_beat      (scale_beat),
    .i_valid     (scale_valid),
    .o_ready     (scale_ready),
    .o_beat      (o_out_beat),
    .o_valid     (o_out_valid),
    .i_ready     (i_out_ready)
  );

endmodule

`default_nettype wire

//--- duc_chain/coarse_rotator.sv
// ------------------------------
// Coarse NCO mixer
// Phase accumulator and quarter-turn rotation
// ------------------------------

`default_nettype none

module coarse_rotator (
  input  wire                  duc_clk,
  input  wire                  i_rst_n,
  input  wire  [31:0]          i_freq,
  input  wire                  i_freq_load,
  input  duc_pkg::duc_beat_t   i_beat,
  input  wire                  i_valid,
  output logic                 o_ready,
  output duc_pkg::duc_beat_t   o_beat,
  output logic                 o_valid,
  input  wire                  i_ready
);

  logic [31:0]         phase_acc;
  logic [1:0]          quadrant;
  logic                take_in;
  duc_pkg::iq_sample_t rot;

  // Negation that keeps -32768 in range
  function automatic logic signed [duc_pkg::IQ_W-1:0] neg_sat(
    input logic signed [duc_pkg::IQ_W-1:0] x
  );
    neg_sat = (x == 16'sh8000) ? 16'sh7FFF : -x;
  endfunction

  assign o_ready  = !o_valid || i_ready;
  assign take_in  = i_valid && o_ready;
  // Phase before the advance picks the quadrant
  assign quadrant = phase_acc[31:30];

  always_comb begin
    case (quadrant)
      2'd0:    rot = '{i: i_beat.sample.i,          q: i_beat.sample.q};
      2'd1:    rot = '{i: neg_sat(i_beat.sample.q), q: i_beat.sample.i};
      2'd2:    rot = '{i: neg_sat(i_beat.sample.i), q: neg_sat(i_beat.sample.q)};
      default: rot = '{i: i_beat.sample.q,          q: neg_sat(i_beat.sample.i)};
    endcase
  end

  always_ff @(posedge duc_clk) begin
    if (!i_rst_n) begin
      o_valid   <= 1'b0;
      phase_acc <= 32'd0;
    end else begin
      if (i_freq_load) begin
        phase_acc <= 32'd0;
      end else if (take_in) begin
        phase_acc <= phase_acc + i_freq;
      end
      if (take_in) begin
        o_valid <= 1'b1;
      end else if (i_ready) begin
        o_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge duc_clk) begin
    if (take_in) begin
      o_beat.sample <= rot;
      o_beat.last   <= i_beat.last;
    end
  end

endmodule

`default_nettype wire

//--- duc_chain/iq_scale.sv
// ------------------------------
// Complex scaler
// Q2.14 multiply with saturation
// ------------------------------

`default_nettype none

module iq_scale (
  input  wire                        duc_clk,
  input  wire                        i_rst_n,
  input  wire signed [15:0]          i_scale,
  input  duc_pkg::duc_beat_t         i_beat,
  input  wire                        i_valid,
  output logic                       o_ready,
  output duc_pkg::duc_beat_t         o_beat,
  output logic                       o_valid,
  input  wire                        i_ready
);

  localparam int PROD_W = 2 * duc_pkg::IQ_W;
  localparam int SHR_W  = PROD_W - duc_pkg::SCALE_FRAC;

  localparam logic signed [SHR_W-1:0] SAT_MAX = SHR_W'(32767);
  localparam logic signed [SHR_W-1:0] SAT_MIN = -SHR_W'(32768);

  // Multiply, floor shift, clamp to 16-bit signed
  function automatic logic signed [duc_pkg::IQ_W-1:0] scale_sat(
    input logic signed [duc_pkg::IQ_W-1:0] x,
    input logic signed [15:0]              s
  );
    logic signed [PROD_W-1:0] prod;
    logic signed [SHR_W-1:0]  shr;
    prod = x * s;
    shr  = prod[PROD_W-1:duc_pkg::SCALE_FRAC];
    if (shr > SAT_MAX) begin
      scale_sat = 16'sh7FFF;
    end else if (shr < SAT_MIN) begin
      scale_sat = 16'sh8000;
    end else begin
      scale_sat = shr[duc_pkg::IQ_W-1:0];
    end
  endfunction

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge duc_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else if (i_valid && o_ready) begin
      o_valid <= 1'b1;
    end else if (i_ready) begin
      o_valid <= 1'b0;
    end
  end

  always_ff @(posedge duc_clk) begin
    if (i_valid && o_ready) begin
      o_beat.sample.i <= scale_sat(i_beat.sample.i, i_scale);
      o_beat.sample.q <= scale_sat(i_beat.sample.q, i_scale);
      o_beat.last     <= i_beat.last;
    end
  end

  a_hold_stalled : assert property (@(posedge duc_clk) disable iff (!i_rst_n)
    (o_valid && !i_ready) |=> (o_valid && $stable(o_beat)));

endmodule

`default_nettype wire

//--- duc_chain/interp_hold.sv
// ------------------------------
// Hold interpolator
// Repeats each input beat M times
// ------------------------------

`default_nettype none

module interp_hold (
  input  wire                  duc_clk,
  input  wire                  i_rst_n,
  input  wire  [7:0]           i_interp,
  input  duc_pkg::duc_beat_t   i_beat,
  input  wire                  i_valid,
  output logic                 o_ready,
  output duc_pkg::duc_beat_t   o_beat,
  output logic                 o_valid,
  input  wire                  i_ready
);

  // Index of the copy now on the output
  logic [7:0] rep_cnt;
  logic       held_last;
  logic       last_rep;
  logic       take_in;

  assign last_rep = (rep_cnt == i_interp - 8'd1);
  // Next beat enters together with the final repeat
  assign o_ready  = !o_valid || (i_ready && last_rep);
  assign take_in  = i_valid && o_ready;

  // Control state
  always_ff @(posedge duc_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
      rep_cnt <= 8'd0;
    end else if (take_in) begin
      o_valid <= 1'b1;
      rep_cnt <= 8'd0;
    end else if (o_valid && i_ready) begin
      if (last_rep) begin
        o_valid <= 1'b0;
      end else begin
        rep_cnt <= rep_cnt + 8'd1;
      end
    end
  end

  // Payload with the last flag on the final copy only
  always_ff @(posedge duc_clk) begin
    if (take_in) begin
      o_beat.sample <= i_beat.sample;
      o_beat.last   <= i_beat.last && (i_interp == 8'd1);
      held_last     <= i_beat.last;
    end else if (o_valid && i_ready && !last_rep) begin
      o_beat.last <= held_last && (rep_cnt + 8'd1 == i_interp - 8'd1);
    end
  end

  a_rep_below_interp : assert property (@(posedge duc_clk) disable iff (!i_rst_n)
    o_valid |-> (rep_cnt < i_interp));

endmodule

`default_nettype wire

//--- source/duc_settings.sv
// ------------------------------
// DUC settings register file
// Frequency, scale and interpolation registers
// Frequency load pulse
// Readback multiplexer
// ------------------------------

`default_nettype none

module duc_settings (
  input  wire                          duc_clk,
  input  wire                          i_rst_n,
  input  wire                          i_set_stb,
  input  wire  [7:0]                   i_set_addr,
  input  wire  [31:0]                  i_set_data,
  input  wire  [7:0]                   i_rb_addr,
  output logic [63:0]                  o_rb_data,
  output duc_regs_pkg::duc_cfg_t       o_cfg,
  output logic                         o_freq_load
);

  duc_regs_pkg::set_word_u set_word;
  logic                    wr_freq;
  logic                    wr_scale_interp;

  assign set_word        = i_set_data;
  assign wr_freq         = i_set_stb && (i_set_addr == duc_regs_pkg::SR_FREQ_ADDR);
  assign wr_scale_interp = i_set_stb && (i_set_addr == duc_regs_pkg::SR_SCALE_INTERP_ADDR);

  // ------------------------------
  // Register writes
  // ------------------------------
  always_ff @(posedge duc_clk) begin
    if (!i_rst_n) begin
      o_cfg       <= duc_regs_pkg::CFG_RESET;
      o_freq_load <= 1'b0;
    end else begin
      o_freq_load <= wr_freq;
      if (wr_freq) begin
        o_cfg.freq <= set_word.freq;
      end
      if (wr_scale_interp) begin
        o_cfg.scale  <= set_word.si.scale;
        o_cfg.interp <= set_word.si.interp;
      end
    end
  end

  // ------------------------------
  // Combinational readback
  // ------------------------------
  always_comb begin
    case (i_rb_addr)
      duc_regs_pkg::RB_COMPAT_ADDR:     o_rb_data = {32'd0, duc_regs_pkg::COMPAT_NUM};
      duc_regs_pkg::RB_MAX_INTERP_ADDR: o_rb_data = 64'(duc_pkg::MAX_INTERP);
      duc_regs_pkg::RB_CONFIG_ADDR:     o_rb_data = {8'd0, o_cfg};
      default:                          o_rb_data = duc_regs_pkg::RB_BAD_ADDR;
    endcase
  end

  // Interpolation outside 1..MAX_INTERP would break the hold stage
  a_interp_range : assert property (@(posedge duc_clk) disable iff (!i_rst_n)
    wr_scale_interp |-> (set_word.si.interp >= 8'd1) &&
                        (set_word.si.interp <= 8'(duc_pkg::MAX_INTERP)));

  // Phase restart is a single-cycle event
  a_freq_load_pulse : assert property (@(posedge duc_clk) disable iff (!i_rst_n)
    o_freq_load |=> !o_freq_load);

endmodule

`default_nettype wire

//--- common/duc_regs_pkg.sv
// ------------------------------
// Control definitions for the DUC
// Settings and readback addresses
// Settings word views and configuration struct
// Readback constants
// ------------------------------

`default_nettype none

package duc_regs_pkg;

  // Settings bus addresses
  localparam logic [7:0] SR_FREQ_ADDR         = 8'd0;
  localparam logic [7:0] SR_SCALE_INTERP_ADDR = 8'd1;

  // Readback addresses
  localparam logic [7:0] RB_COMPAT_ADDR     = 8'd0;
  localparam logic [7:0] RB_MAX_INTERP_ADDR = 8'd1;
  localparam logic [7:0] RB_CONFIG_ADDR     = 8'd2;

  // Version word with the major number in the upper half
  localparam logic [31:0] COMPAT_NUM  = 32'h0001_0000;
  localparam logic [63:0] RB_BAD_ADDR = 64'h0BAD_C0DE_0BAD_C0DE;

  // Unity gain in Q2.14
  localparam logic signed [15:0] SCALE_UNITY = 16'sd16384;

  // Scale and interpolation view of a settings word
  typedef struct packed {
    logic [7:0]         rsvd;
    logic [7:0]         interp;
    logic signed [15:0] scale;
  } scale_interp_t;

  // Meaning depends on the settings address
  typedef union packed {
    logic [31:0]   freq;
    scale_interp_t si;
  } set_word_u;

  // Live configuration seen by the stages
  typedef struct packed {
    logic [31:0]        freq;
    logic signed [15:0] scale;
    logic [7:0]         interp;
  } duc_cfg_t;

  localparam duc_cfg_t CFG_RESET = '{freq: 32'd0, scale: SCALE_UNITY, interp: 8'd1};

endpackage

`default_nettype wire

//--- common/duc_pkg.sv
// ------------------------------
// Datapath definitions for the DUC chain
// Sample and beat types
// Component width and size limits
// ------------------------------

`default_nettype none

package duc_pkg;

  // Width of one I or Q component
  localparam int IQ_W = 16;

  // Largest supported interpolation factor
  localparam int MAX_INTERP = 16;

  // Fraction bits of the Q2.14 scale
  localparam int SCALE_FRAC = 14;

  // One complex sample with I in the upper half
  typedef struct packed {
    logic signed [IQ_W-1:0] i;
    logic signed [IQ_W-1:0] q;
  } iq_sample_t;

  // Sample plus end-of-burst marker
  typedef struct packed {
    iq_sample_t sample;
    logic       last;
  } duc_beat_t;

endpackage

`default_nettype wire
